// File: build.f
+incdir+include
src/farm_pkg.sv
src/farm_sample_if.sv
src/sample_averager.sv
src/sensor_fault_detector.sv
src/range_checker.sv
src/farm_monitor.sv
test/tb_farm_monitor.sv

// File: include/farm_config.svh
/*
 * Reading width, history depth and alert bounds for the sensor monitor
 * Bounds are inclusive and apply to the four-sample average
 * History depth must stay a power of two so the write index wraps
 */
`ifndef FARM_CONFIG_SVH
`define FARM_CONFIG_SVH

`define FARM_SAMPLE_W   8           // Raw reading width
`define FARM_HIST_DEPTH 4           // Entries per channel in the mean

// ==========================================================================
// Acceptable ranges per channel
// ==========================================================================
`define FARM_SOIL_MIN   140         // Too dry below
`define FARM_SOIL_MAX   210         // Too wet above
`define FARM_TEMP_MIN   100         // Too cold
`define FARM_TEMP_MAX   160         // Too hot
`define FARM_HUMID_MIN  120
`define FARM_HUMID_MAX  190
// Light is scaled intensity
`define FARM_LIGHT_MIN  80          // Too dark
`define FARM_LIGHT_MAX  220         // Too bright

`endif

// File: run.sh
#!/bin/sh
# Build and run the sensor monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
    --top-module tb_farm_monitor -Mdir obj_dir -o sim_farm

sim_rc=0
sim_out=$(./obj_dir/sim_farm 2>&1) || sim_rc=$?
printf '%s\n' "$sim_out"

if [ "$sim_rc" -eq 0 ] && printf '%s\n' "$sim_out" | grep -qxF '>>> PASS'; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: src/farm_monitor.sv
/*
 * Four-channel sensor monitor top level
 * Outputs follow a reading two clock edges after it is sampled
 * sensor_sel is 0 soil, 1 temperature, 2 humidity, 3 light
 */
`default_nettype none

module farm_monitor
    import farm_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sample_valid,    // Plain strobe, no handshake
    input  logic [1:0] sensor_sel,
    input  logic [7:0] sample,
    output logic       buzzer,
    output logic [7:0] status,          // Average of last channel read
    output logic [3:0] alert_code,
    output logic [3:0] fault_code
);

    // Averaged reading to both checkers
    farm_sample_if smp_if ();

    sample_averager i_averager (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sample_valid),
        .in_chan   (chan_t'(sensor_sel)),
        .in_sample (sample),
        .out       (smp_if.src)
    );

    sensor_fault_detector i_fault_detector (
        .clk        (clk),
        .rst_n      (rst_n),
        .smp        (smp_if.dst),
        .fault_code (fault_code)
    );

    // Fault flags also feed the buzzer here
    range_checker i_range_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .smp        (smp_if.dst),
        .fault_code (fault_code),
        .alert_code (alert_code),
        .status     (status),
        .buzzer     (buzzer)
    );

endmodule

`default_nettype wire

// File: src/farm_pkg.sv
/*
 * Types shared by the monitor pipeline
 * Flag vectors carry one bit per channel, indexed by the channel code
 */
`default_nettype none

`include "farm_config.svh"

package farm_pkg;

    // One reading or one average
    typedef logic [`FARM_SAMPLE_W-1:0] sample_t;

    // Room for the sum of a full history without overflow
    typedef logic [`FARM_SAMPLE_W+$clog2(`FARM_HIST_DEPTH)-1:0] sum_t;

    // Sensor select encoding
    typedef enum logic [1:0] {
        CH_SOIL = 2'd0, CH_TEMP = 2'd1, CH_HUMID = 2'd2, CH_LIGHT = 2'd3
    } chan_t;

    typedef logic [3:0] flags_t;    // Bit n belongs to channel n

endpackage

`default_nettype wire

// File: src/farm_sample_if.sv
/*
 * One averaged reading, published for a single cycle
 * No back-pressure; every valid must be taken on that cycle
 */
`default_nettype none

interface farm_sample_if
    import farm_pkg::*;
();

    logic    valid;     // One-cycle strobe
    chan_t   chan;      // Channel the reading came from
    sample_t raw;       // Reading as received
    sample_t avg;       // New mean of that channel

    // Averager side
    modport src (
        output valid,
        output chan,
        output raw,
        output avg
    );

    // Fault detector and range checker side
    modport dst (
        input valid,
        input chan,
        input raw,
        input avg
    );

endinterface

`default_nettype wire

// File: src/range_checker.sv
/*
 * Threshold alerts on the channel average, the status byte and the buzzer
 * Bounds are inclusive, taken from the config header
 * Buzzer is combinational from the alert register and the fault flags
 */
`default_nettype none

`include "farm_config.svh"

module range_checker
    import farm_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    farm_sample_if.dst smp,
    input  flags_t     fault_code,
    output flags_t     alert_code,
    output sample_t    status,
    output logic       buzzer
);

    sample_t lo_bound;
    sample_t hi_bound;
    logic    out_of_range;

    // ======================================================================
    // Bound select for the incoming channel
    // ======================================================================
    always_comb begin
        case (smp.chan)
            CH_SOIL: begin
                lo_bound = sample_t'(`FARM_SOIL_MIN);
                hi_bound = sample_t'(`FARM_SOIL_MAX);
            end
            CH_TEMP: begin
                lo_bound = sample_t'(`FARM_TEMP_MIN);
                hi_bound = sample_t'(`FARM_TEMP_MAX);
            end
            CH_HUMID: begin
                lo_bound = sample_t'(`FARM_HUMID_MIN);
                hi_bound = sample_t'(`FARM_HUMID_MAX);
            end
            default: begin                                  // CH_LIGHT
                lo_bound = sample_t'(`FARM_LIGHT_MIN);
                hi_bound = sample_t'(`FARM_LIGHT_MAX);
            end
        endcase
        out_of_range = (smp.avg < lo_bound) || (smp.avg > hi_bound);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alert_code <= '0;
            status     <= '0;
        end else if (smp.valid) begin
            alert_code[smp.chan] <= out_of_range;           // Others hold
            status               <= smp.avg;                // Latest channel read
        end
    end

    assign buzzer = (|alert_code) | (|fault_code);

    // Averaged payload must be clean on every strobe
    a_payload_known: assert property (@(posedge clk) disable iff (!rst_n)
        smp.valid |-> !$isunknown({smp.chan, smp.avg}));

endmodule

`default_nettype wire

// File: src/sample_averager.sv
/*
 * Running mean over the last four readings of each channel
 * Histories and sums start at zero, so the first averages are pulled low
 * Output payload is only meaningful while out.valid is high
 * One cycle of latency and a new reading may arrive every cycle
 */
`default_nettype none

`include "farm_config.svh"

module sample_averager
    import farm_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  chan_t      in_chan,
    input  sample_t    in_sample,
    farm_sample_if.src out
);

    localparam int NUM_CH = $bits(flags_t);                 // One flag per channel
    localparam int IDX_W  = $clog2(`FARM_HIST_DEPTH);

    // ======================================================================
    // Per-channel state
    // ======================================================================
    sample_t          hist   [NUM_CH][`FARM_HIST_DEPTH];
    logic [IDX_W-1:0] wr_idx [NUM_CH];                      // Oldest entry
    sum_t             sum_q  [NUM_CH];

    sample_t oldest;
    sum_t    new_sum;

    // Replace the oldest entry in the running sum
    always_comb begin
        oldest  = hist[in_chan][wr_idx[in_chan]];
        new_sum = sum_q[in_chan] - sum_t'(oldest) + sum_t'(in_sample);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int c = 0; c < NUM_CH; c++) begin
                for (int e = 0; e < `FARM_HIST_DEPTH; e++) begin
                    hist[c][e] <= '0;
                end
                wr_idx[c] <= '0;
                sum_q[c]  <= '0;
            end
        end else if (in_valid) begin
            hist[in_chan][wr_idx[in_chan]] <= in_sample;
            wr_idx[in_chan] <= wr_idx[in_chan] + 1'b1;      // Wraps at depth
            sum_q[in_chan]  <= new_sum;
        end
    end

    // ======================================================================
    // Output stage
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in_valid;
        end
    end

    // Payload regs, no reset
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out.chan <= in_chan;
            out.raw  <= in_sample;
            out.avg  <= new_sum[IDX_W +: `FARM_SAMPLE_W];     // Truncated divide by depth
        end
    end

    // Channel select must be clean on every strobe
    a_chan_known: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !$isunknown(in_chan));

    // Running sum matches the stored history of the channel being read
    a_sum_track: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> (sum_q[in_chan] == sum_t'(hist[in_chan][0]) + sum_t'(hist[in_chan][1])
                      + sum_t'(hist[in_chan][2]) + sum_t'(hist[in_chan][3])));

endmodule

`default_nettype wire

// File: src/sensor_fault_detector.sv
/*
 * Stuck and extreme fault flags per channel
 * Stuck compares against the previous raw reading, which is zero after reset
 * A channel's flags only move on a reading of that channel
 */
`default_nettype none

module sensor_fault_detector
    import farm_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    farm_sample_if.dst smp,
    output flags_t     fault_code
);

    localparam int NUM_CH = $bits(flags_t);

    sample_t last_raw [NUM_CH];     // Previous reading per channel
    flags_t  stuck_q;
    flags_t  extreme_q;

    logic is_stuck;
    logic is_extreme;

    // ======================================================================
    // Fault tests on the incoming reading
    // ======================================================================
    always_comb begin
        is_stuck   = (smp.raw == last_raw[smp.chan]);
        is_extreme = (smp.avg == '0) || (smp.avg == '1);   // Rail at 0 or full scale
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int c = 0; c < NUM_CH; c++) begin
                last_raw[c] <= '0;
            end
            stuck_q   <= '0;
            extreme_q <= '0;
        end else if (smp.valid) begin
            stuck_q[smp.chan]   <= is_stuck;
            extreme_q[smp.chan] <= is_extreme;
            last_raw[smp.chan]  <= smp.raw;                 // Always track latest
        end
    end

    // Either fault marks the channel
    assign fault_code = stuck_q | extreme_q;

endmodule

`default_nettype wire

// File: test/tb_farm_monitor.sv
/*
 * Testbench for the four-channel sensor monitor
 * Directed rows are checked two rising edges after they are driven
 * Random phase runs a behavioral model of histories, last readings and flags
 */
`default_nettype none

`include "farm_config.svh"

module tb_farm_monitor
    import farm_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int N_RAND     = 200;        // Readings in the random phase

    logic       clk = 1'b0;
    logic       rst_n;
    logic       sample_valid;
    logic [1:0] sensor_sel;
    logic [7:0] sample;
    logic       buzzer;
    logic [7:0] status;
    logic [3:0] alert_code;
    logic [3:0] fault_code;

    int n_checks = 0;
    int n_errors = 0;

    // Directed table columns, expected packed as {status, alert, fault, buzzer}
    string       t_name [$];
    logic [1:0]  t_chan [$];
    logic [7:0]  t_smp  [$];
    logic        t_vld  [$];
    logic [16:0] t_exp  [$];

    // ======================================================================
    // Reference model state
    // ======================================================================
    logic [7:0]  m_hist [4][4];
    logic [1:0]  m_idx  [4];                // Oldest entry per channel
    logic [7:0]  m_last [4];
    logic [3:0]  m_alert;
    logic [3:0]  m_fault;
    logic [7:0]  m_status;
    logic [16:0] exp_q  [$];                // One entry per random-phase cycle
    int          num_q  [$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    farm_monitor i_farm_monitor (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sensor_sel   (sensor_sel),
        .sample       (sample),
        .buzzer       (buzzer),
        .status       (status),
        .alert_code   (alert_code),
        .fault_code   (fault_code)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_row(input string name, input logic [1:0] ch, input logic [7:0] smp,
                           input logic vld, input logic [7:0] st, input logic [3:0] al,
                           input logic [3:0] fl, input logic bz);
        t_name.push_back(name);
        t_chan.push_back(ch);
        t_smp.push_back(smp);
        t_vld.push_back(vld);
        t_exp.push_back({st, al, fl, bz});
    endtask

    // Mean of the last four, inclusive bounds, stuck against previous raw
    task automatic model_step(input logic [1:0] ch, input logic [7:0] v);
        int avg;
        int lo;
        int hi;
        m_hist[ch][m_idx[ch]] = v;
        m_idx[ch] = m_idx[ch] + 2'd1;
        avg = (int'(m_hist[ch][0]) + int'(m_hist[ch][1]) + int'(m_hist[ch][2])
            + int'(m_hist[ch][3])) / 4;
        lo = (ch == 2'd0) ? `FARM_SOIL_MIN : (ch == 2'd1) ? `FARM_TEMP_MIN
           : (ch == 2'd2) ? `FARM_HUMID_MIN : `FARM_LIGHT_MIN;
        hi = (ch == 2'd0) ? `FARM_SOIL_MAX : (ch == 2'd1) ? `FARM_TEMP_MAX
           : (ch == 2'd2) ? `FARM_HUMID_MAX : `FARM_LIGHT_MAX;
        m_alert[ch] = (avg < lo) || (avg > hi);
        m_fault[ch] = (v == m_last[ch]) || (avg == 0) || (avg == 255);
        m_last[ch]  = v;
        m_status    = 8'(avg);
    endtask

    function automatic logic [16:0] predicted_outputs();
        return {m_status, m_alert, m_fault, (|m_alert) || (|m_fault)};
    endfunction

    task automatic check_outputs(input string name, input logic [16:0] e);
        n_checks++;
        assert (status == e[16:9]) else begin
            $display("MISMATCH %s status expected %0d actual %0d", name, e[16:9], status);
            n_errors++;
        end
        assert (alert_code == e[8:5]) else begin
            $display("MISMATCH %s alert_code expected %b actual %b", name, e[8:5], alert_code);
            n_errors++;
        end
        assert (fault_code == e[4:1]) else begin
            $display("MISMATCH %s fault_code expected %b actual %b", name, e[4:1], fault_code);
            n_errors++;
        end
        assert (buzzer == e[0]) else begin
            $display("MISMATCH %s buzzer expected %b actual %b", name, e[0], buzzer);
            n_errors++;
        end
    endtask

    // ======================================================================
    // Stimulus and checks
    // ======================================================================
    initial begin
        logic [31:0] rng;
        logic [1:0]  ch;
        logic [7:0]  v;
        int          n_rd;
        int          tail;
        add_row("reset_idle",  CH_SOIL,  8'd0,   1'b0, 8'd0,   4'b0000, 4'b0000, 1'b0);
        add_row("soil_1",      CH_SOIL,  8'd160, 1'b1, 8'd40,  4'b0001, 4'b0000, 1'b1);
        add_row("temp_1",      CH_TEMP,  8'd130, 1'b1, 8'd32,  4'b0011, 4'b0000, 1'b1);
        add_row("soil_2",      CH_SOIL,  8'd170, 1'b1, 8'd82,  4'b0011, 4'b0000, 1'b1);
        add_row("temp_2",      CH_TEMP,  8'd131, 1'b1, 8'd65,  4'b0011, 4'b0000, 1'b1);
        add_row("soil_3",      CH_SOIL,  8'd180, 1'b1, 8'd127, 4'b0011, 4'b0000, 1'b1);
        add_row("soil_4",      CH_SOIL,  8'd190, 1'b1, 8'd175, 4'b0010, 4'b0000, 1'b1);
        add_row("temp_min",    CH_TEMP,  8'd140, 1'b1, 8'd100, 4'b0000, 4'b0000, 1'b0);
        add_row("light_low",   CH_LIGHT, 8'd200, 1'b1, 8'd50,  4'b1000, 4'b0000, 1'b1);
        add_row("light_min",   CH_LIGHT, 8'd120, 1'b1, 8'd80,  4'b0000, 4'b0000, 1'b0);
        add_row("light_in_1",  CH_LIGHT, 8'd250, 1'b1, 8'd142, 4'b0000, 4'b0000, 1'b0);
        add_row("light_in_2",  CH_LIGHT, 8'd240, 1'b1, 8'd202, 4'b0000, 4'b0000, 1'b0);
        add_row("light_in_3",  CH_LIGHT, 8'd250, 1'b1, 8'd215, 4'b0000, 4'b0000, 1'b0);
        add_row("light_max",   CH_LIGHT, 8'd140, 1'b1, 8'd220, 4'b0000, 4'b0000, 1'b0);
        add_row("light_high",  CH_LIGHT, 8'd254, 1'b1, 8'd221, 4'b1000, 4'b0000, 1'b1);
        add_row("light_back",  CH_LIGHT, 8'd200, 1'b1, 8'd211, 4'b0000, 4'b0000, 1'b0);
        add_row("humid_1",     CH_HUMID, 8'd150, 1'b1, 8'd37,  4'b0100, 4'b0000, 1'b1);
        add_row("humid_stuck", CH_HUMID, 8'd150, 1'b1, 8'd75,  4'b0100, 4'b0100, 1'b1);
        add_row("humid_clear", CH_HUMID, 8'd160, 1'b1, 8'd115, 4'b0100, 4'b0000, 1'b1);
        add_row("humid_ff_1",  CH_HUMID, 8'd255, 1'b1, 8'd178, 4'b0000, 4'b0000, 1'b0);
        add_row("humid_ff_2",  CH_HUMID, 8'd255, 1'b1, 8'd205, 4'b0100, 4'b0100, 1'b1);
        add_row("humid_ff_3",  CH_HUMID, 8'd255, 1'b1, 8'd231, 4'b0100, 4'b0100, 1'b1);
        add_row("humid_ff_4",  CH_HUMID, 8'd255, 1'b1, 8'd255, 4'b0100, 4'b0100, 1'b1);
        add_row("humid_off",   CH_HUMID, 8'd254, 1'b1, 8'd254, 4'b0100, 4'b0000, 1'b1);
        // Zero average with no repeat, extreme fault on its own
        add_row("temp_lo_1",   CH_TEMP,  8'd1,   1'b1, 8'd100, 4'b0100, 4'b0000, 1'b1);
        add_row("temp_lo_2",   CH_TEMP,  8'd0,   1'b1, 8'd68,  4'b0110, 4'b0000, 1'b1);
        add_row("temp_lo_3",   CH_TEMP,  8'd2,   1'b1, 8'd35,  4'b0110, 4'b0000, 1'b1);
        add_row("temp_zero",   CH_TEMP,  8'd0,   1'b1, 8'd0,   4'b0110, 4'b0010, 1'b1);
        for (int c = 0; c < 4; c++) begin
            for (int e = 0; e < 4; e++) begin
                m_hist[c][e] = '0;
            end
            m_idx[c]  = '0;
            m_last[c] = '0;
        end
        m_alert      = '0;
        m_fault      = '0;
        m_status     = '0;
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sensor_sel   = 2'd0;
        sample       = 8'd0;
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;

        // Directed rows, model kept in step for the random phase
        for (int i = 0; i < t_name.size(); i++) begin
            sample_valid = t_vld[i];
            sensor_sel   = t_chan[i];
            sample       = t_smp[i];
            if (t_vld[i]) model_step(t_chan[i], t_smp[i]);
            @(posedge clk);
            #2 sample_valid = 1'b0;
            @(posedge clk);
            #1 check_outputs(t_name[i], t_exp[i]);
            #1;
        end

        // Random phase, mostly back-to-back strobes
        rng  = 32'd45017;
        n_rd = 0;
        tail = 0;
        while (tail < 3) begin
            @(posedge clk);
            #1;
            if (exp_q.size() == 2) check_outputs($sformatf("rand_%0d", num_q.pop_front()),
                                                 exp_q.pop_front());
            #1;
            if (n_rd < N_RAND) begin
                rng = xorshift32(rng);
                ch  = rng[4:3];
                case (rng[7:5])
                    3'd0:    v = m_last[ch];            // Repeat, stuck fault
                    3'd1:    v = 8'hFF;                 // Pushes toward full scale
                    3'd2:    v = {6'd0, rng[9:8]};      // Pulls toward zero
                    default: v = rng[15:8];
                endcase
                sample_valid = (rng[2:0] != 3'd0);
                sensor_sel   = ch;
                sample       = v;
                if (sample_valid) begin
                    model_step(ch, v);
                    n_rd++;
                end
            end else begin
                sample_valid = 1'b0;
                tail++;
            end
            exp_q.push_back(predicted_outputs());
            num_q.push_back(n_rd);
        end

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog sized from the table length and the random phase
    initial begin
        int limit;
        #1;
        limit = (t_name.size() + N_RAND + 20) * 3 * CLK_PERIOD;
        #(limit - 1);
        $display("ERROR: timeout, run still going after %0d ns", limit);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
